//--- Makefile
# Verilator build and run of the HPU group testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_hpu_group -f build.f -o sim_hpu_group
	./obj_dir/sim_hpu_group | tee /dev/stderr | grep "Finished with no errors" > /dev/null

clean:
	rm -rf obj_dir

//--- build.f
verilog/hpu_task_pkg.sv
verilog/hpu_mem_pkg.sv
verilog/stream_fifo.sv
verilog/task_frontend.sv
verilog/feedback_arbiter.sv
verilog/hpu_group_top.sv
verif/tb_hpu_group.sv

//--- verif/frontend_input.txt
// op hpu arg value: 1 task(base, fun) 2 read(addr, data) 3 unmapped read(addr, data)
// 4 write(addr, wdata) 5 feedback(base) 6 allowed(-, level) 7 pair terminate
// 8 blocked(cycles) 9 boot poll, f end of test (number in hpu column), 0 end of list
9 0 0 0
9 1 0 0
1 0 10000000 a000
2 0 00 a000
2 0 04 10000001
2 0 08 10000002
2 0 0c 10000003
2 0 10 10000004
2 0 14 10000005
2 0 18 10000006
2 0 1c 10000007
2 0 20 10000008
2 0 24 10000009
2 0 28 1000000a
2 0 2c 1000000b
2 0 30 1000000c
2 0 34 1000000d
2 0 38 2
2 0 3c 1000000e
f 1 0 0
3 0 48 0
4 0 44 deadbeef
f 2 0 0
2 0 40 0
5 0 10000000 0
f 3 0 0
1 0 20000000 b000
6 0 0 0
2 0 40 0
8 0 5 0
6 0 0 1
5 0 20000000 0
f 4 0 0
1 0 30000000 c000
1 1 40000000 d000
7 0 0 0
5 1 40000000 0
5 0 30000000 0
f 5 0 0
1 1 50000000 0
5 1 50000000 0
f 6 0 0
1 0 60000000 e000
1 1 70000000 f000
7 0 0 0
5 0 60000000 0
5 1 70000000 0
f 7 0 0
0 0 0 0

//--- verif/tb_hpu_group.sv
/*
 * HPU group testbench
 * plays the scheduler and the cores from a stimulus file and checks
 * register reads, core responses and the feedback stream
 */
`timescale 1ns/1ns

module tb_hpu_group;

    import hpu_task_pkg::*;
    import hpu_mem_pkg::*;

    localparam int NUM_HPUS = 2;
    localparam int TIMEOUT  = 200;  // cycles per wait
    localparam int MAX_OPS  = 64;

    logic                           clk_i;
    logic                           rst_ni;
    logic            [NUM_HPUS-1:0] task_valid;
    logic            [NUM_HPUS-1:0] task_ready;
    hpu_task_t       [NUM_HPUS-1:0] task_data;
    core_req_t       [NUM_HPUS-1:0] core_req;
    core_rsp_t       [NUM_HPUS-1:0] core_rsp;
    logic                           fb_allowed;
    logic                           fb_valid;
    logic                           fb_ready;
    feedback_descr_t                fb_data;
    logic            [NUM_HPUS-1:0] active;
    logic            [NUM_HPUS-1:0] disable_cmds;
    logic            [NUM_HPUS-1:0] terminated;

    logic [31:0] ops [4*MAX_OPS];   // op, hpu, arg, value per line
    int          errors;
    int          test_errors;
    bit          timed_out;
    integer      seed;

    hpu_group_top #(
        .NUM_HPUS     (NUM_HPUS),
        .NUM_CLUSTERS (4)
    ) DUT (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .task_valid_i         (task_valid),
        .task_ready_o         (task_ready),
        .task_i               (task_data),
        .core_req_i           (core_req),
        .core_rsp_o           (core_rsp),
        .feedback_allowed_i   (fb_allowed),
        .feedback_valid_o     (fb_valid),
        .feedback_ready_i     (fb_ready),
        .feedback_o           (fb_data),
        .active_o             (active),
        .disable_commands_o   (disable_cmds),
        .handler_terminated_o (terminated)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // task fields are numbered up from a base word
    function automatic hpu_task_t make_task(input logic [31:0] base, input logic [31:0] fun);
        hpu_task_t t;
        t                                     = '0;
        t.handler_task.handler_fun            = fun;
        t.handler_task.handler_fun_size       = base + 32'h1;
        t.handler_task.handler_mem_addr       = base + 32'h2;
        t.handler_task.handler_mem_size       = base + 32'h3;
        t.pkt_ptr                             = base + 32'h4;
        t.handler_task.pkt_size               = base + 32'h5;
        t.handler_task.scratchpad_addr[0]     = base + 32'h6;
        t.handler_task.scratchpad_addr[1]     = base + 32'h7;
        t.handler_task.scratchpad_size[0]     = base + 32'h8;
        t.handler_task.scratchpad_size[1]     = base + 32'h9;
        t.handler_task.host_mem_addr          = {base + 32'ha, base + 32'hb};
        t.handler_task.host_mem_size          = base + 32'hc;
        t.handler_task.pkt_addr               = base + 32'hd;
        t.handler_task.msgid                  = base + 32'he;
        t.handler_task.trigger_feedback       = 1'b1;
        return t;
    endfunction

    function automatic feedback_descr_t expected_feedback(input logic [31:0] base, input int h);
        feedback_descr_t f;
        hpu_task_t       t;
        t                  = make_task(base, 32'h1);
        f.pkt_ptr          = t.pkt_ptr;
        f.pkt_addr         = t.handler_task.pkt_addr;
        f.msgid            = t.handler_task.msgid;
        f.pkt_size         = t.handler_task.pkt_size;
        f.trigger_feedback = t.handler_task.trigger_feedback;
        f.hpu_id           = 8'(h);
        return f;
    endfunction

    task automatic check(input logic [159:0] got, input logic [159:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t %s: got %0h, expected %0h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        errors++;
        test_errors++;
        timed_out = 1'b1;
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    // first request after reset moves the frontend out of Init
    task automatic boot_poll(input int h);
        int n;
        repeat (3) begin
            @(negedge clk_i);
            check(task_ready[h], 1'b0, "task_ready_o before boot poll");
            check(fb_valid, 1'b0, "feedback_valid_o before boot poll");
            check(active[h], 1'b0, "active_o before boot poll");
            check(disable_cmds[h], 1'b0, "disable_commands_o after reset");
        end
        next_cycle();
        core_req[h].q_valid = 1'b1;
        core_req[h].q.addr  = 32'(REG_HANDLER_FUN);
        n = 0;
        @(negedge clk_i);
        while (!task_ready[h] && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!task_ready[h]) report_timeout("task_ready_o after boot poll");
        check(core_rsp[h].p_valid, 1'b0, "boot poll answered");
        next_cycle();
        core_req[h].q_valid = 1'b0;
    endtask

    task automatic load_task(input int h, input logic [31:0] base, input logic [31:0] fun);
        int n;
        task_data[h]  = make_task(base, fun);
        task_valid[h] = 1'b1;
        n = 0;
        @(negedge clk_i);
        while (!task_ready[h] && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!task_ready[h]) report_timeout("task handover");
        next_cycle();
        task_valid[h] = 1'b0;
    endtask

    task automatic core_access(input int h, input logic [31:0] addr, input logic write,
                               input logic [31:0] wdata, input logic [31:0] exp_data,
                               input logic exp_err);
        int   n;
        int   gap;
        logic term_seen;
        core_req[h].q_valid = 1'b1;
        core_req[h].q.addr  = addr;
        core_req[h].q.write = write;
        core_req[h].q.data  = wdata;
        n = 0;
        @(negedge clk_i);
        while (!core_rsp[h].q_ready && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        term_seen = terminated[h];  // pulse only in the accept cycle
        if (!core_rsp[h].q_ready) begin
            report_timeout("request accept");
            core_req[h].q_valid = 1'b0;
            return;
        end
        check(active[h], 1'b1, "active_o while a handler runs");
        next_cycle();
        core_req[h].q_valid = 1'b0;
        check(term_seen, (addr[7:0] == REG_TERMINATE) && !write, "handler_terminated_o");
        gap = $random(seed) & 3;
        repeat (gap) next_cycle();
        core_req[h].p_ready = 1'b1;
        n = 0;
        @(negedge clk_i);
        while (!core_rsp[h].p_valid && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!core_rsp[h].p_valid) report_timeout("core response");
        check(core_rsp[h].p.data, exp_data, "response data");
        check(core_rsp[h].p.error, exp_err, "response error");
        next_cycle();
        core_req[h].p_ready = 1'b0;
    endtask

    // both handlers read the termination register in the same cycle
    task automatic terminate_pair();
        int n;
        for (int h = 0; h < NUM_HPUS; h++) begin
            core_req[h].q_valid = 1'b1;
            core_req[h].q.addr  = 32'(REG_TERMINATE);
            core_req[h].q.write = 1'b0;
        end
        n = 0;
        @(negedge clk_i);
        while (!(core_rsp[0].q_ready && core_rsp[1].q_ready) && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (n >= TIMEOUT) report_timeout("accept of both termination reads");
        check(terminated, 2'b11, "handler_terminated_o on both");
        next_cycle();
        core_req[0].q_valid = 1'b0;
        core_req[1].q_valid = 1'b0;
        core_req[0].p_ready = 1'b1;
        core_req[1].p_ready = 1'b1;
        n = 0;
        @(negedge clk_i);
        while (!(core_rsp[0].p_valid && core_rsp[1].p_valid) && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (n >= TIMEOUT) report_timeout("both termination responses");
        for (int h = 0; h < NUM_HPUS; h++) begin
            check(core_rsp[h].p, '0, "termination response");
        end
        next_cycle();
        core_req[0].p_ready = 1'b0;
        core_req[1].p_ready = 1'b0;
    endtask

    task automatic take_feedback(input int h, input logic [31:0] base);
        int n;
        fb_ready = 1'b1;
        n = 0;
        @(negedge clk_i);
        while (!fb_valid && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!fb_valid) report_timeout("feedback");
        check(fb_data, expected_feedback(base, h), "feedback descriptor");
        next_cycle();
        fb_ready = 1'b0;    // one transfer only
        @(negedge clk_i);
        check(task_ready[h], 1'b1, "task_ready_o after feedback handover");
        next_cycle();
    endtask

    // feedback pending but not allowed out
    task automatic hold_blocked(input int h, input int cycles);
        fb_ready = 1'b1;
        repeat (cycles) begin
            @(negedge clk_i);
            check(fb_valid, 1'b0, "feedback_valid_o while not allowed");
            check(disable_cmds[h], 1'b1, "disable_commands_o while held");
            check(task_ready[h], 1'b0, "task_ready_o while held");
        end
        next_cycle();
        fb_ready = 1'b0;
    endtask

    initial begin
        int          i;
        int          tests;
        int          hpu;
        logic [31:0] op;
        logic [31:0] arg;
        logic [31:0] val;
        seed        = 30265;
        errors      = 0;
        test_errors = 0;
        tests       = 0;
        timed_out   = 1'b0;
        rst_ni      = 1'b0;
        task_valid  = '0;
        task_data   = '0;
        core_req    = '0;
        fb_allowed  = 1'b1;
        fb_ready    = 1'b0;
        $readmemh("verif/frontend_input.txt", ops);
        repeat (4) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        i = 0;
        while (!timed_out && i < MAX_OPS && ops[4*i] != 32'h0) begin
            op  = ops[4*i];
            hpu = int'(ops[4*i+1]);
            arg = ops[4*i+2];
            val = ops[4*i+3];
            case (op)
                32'h1: load_task(hpu, arg, val);
                32'h2: core_access(hpu, arg, 1'b0, '0, val, 1'b0);
                32'h3: core_access(hpu, arg, 1'b0, '0, val, 1'b1); // unmapped
                32'h4: core_access(hpu, arg, 1'b1, val, 32'h0, 1'b0);
                32'h5: take_feedback(hpu, arg);
                32'h6: begin
                    fb_allowed = val[0];
                    next_cycle();
                end
                32'h7: terminate_pair();
                32'h8: hold_blocked(hpu, int'(arg));
                32'h9: boot_poll(hpu);
                32'hf: begin
                    $display("test %0d done: %0d errors", hpu, test_errors);
                    tests++;
                    test_errors = 0;
                end
                default: begin
                    $display("stimulus line %0d holds an unknown op %0h", i, op);
                    errors++;
                end
            endcase
            i++;
        end
        $display("%0d tests run, %0d errors in total", tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- verilog/feedback_arbiter.sv
/*
 * feedback arbiter
 * round-robin merge of NUM_PORTS valid/ready streams onto one output,
 * granted only while allowed_i is high. The winner index goes into the
 * hpu_id field of the outgoing descriptor.
 */
`timescale 1ns/1ns

module feedback_arbiter #(
    parameter int unsigned NUM_PORTS = 2,
    parameter type         T         = hpu_task_pkg::feedback_descr_t
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    input  logic [NUM_PORTS-1:0] req_valid_i,
    output logic [NUM_PORTS-1:0] req_ready_o,
    input  T     [NUM_PORTS-1:0] req_i,

    input  logic                 allowed_i,

    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output T                     out_o
);

    localparam int unsigned IdxW = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    logic [IdxW-1:0] last_q;
    logic [IdxW-1:0] winner;
    logic            found;

    // first pending port after the last winner
    always_comb begin
        int unsigned cand;
        found  = 1'b0;
        winner = last_q;
        for (int unsigned i = 1; i <= NUM_PORTS; i++) begin
            cand = (32'(last_q) + i) % NUM_PORTS;
            if (!found && req_valid_i[cand]) begin
                found  = 1'b1;
                winner = IdxW'(cand);
            end
        end
    end

    assign out_valid_o = allowed_i && found;

    always_comb begin
        req_ready_o         = '0;
        req_ready_o[winner] = out_valid_o && out_ready_i;
    end

    always_comb begin
        out_o        = req_i[winner];
        out_o.hpu_id = 8'(winner);
    end

    // rotate only on a completed transfer
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            last_q <= IdxW'(NUM_PORTS - 1); // port 0 goes first
        end else if (out_valid_o && out_ready_i) begin
            last_q <= winner;
        end
    end

endmodule

//--- verilog/hpu_group_top.sv
/*
 * HPU group top
 * NUM_HPUS task frontends, one per core, with their feedback merged by a
 * round-robin arbiter onto a single feedback port
 */
`timescale 1ns/1ns

module hpu_group_top #(
    parameter int unsigned NUM_HPUS     = 2,
    parameter int unsigned NUM_CLUSTERS = 4
) (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,

    input  logic [NUM_HPUS-1:0]                    task_valid_i,
    output logic [NUM_HPUS-1:0]                    task_ready_o,
    input  hpu_task_pkg::hpu_task_t [NUM_HPUS-1:0] task_i,

    input  hpu_mem_pkg::core_req_t  [NUM_HPUS-1:0] core_req_i,
    output hpu_mem_pkg::core_rsp_t  [NUM_HPUS-1:0] core_rsp_o,

    input  logic                                   feedback_allowed_i,
    output logic                                   feedback_valid_o,
    input  logic                                   feedback_ready_i,
    output hpu_task_pkg::feedback_descr_t          feedback_o,

    output logic [NUM_HPUS-1:0]                    active_o,
    output logic [NUM_HPUS-1:0]                    disable_commands_o,
    output logic [NUM_HPUS-1:0]                    handler_terminated_o
);

    import hpu_task_pkg::*;

    logic            [NUM_HPUS-1:0] fb_valid;
    logic            [NUM_HPUS-1:0] fb_ready;
    feedback_descr_t [NUM_HPUS-1:0] fb;

    for (genvar k = 0; k < NUM_HPUS; k++) begin : g_frontend
        task_frontend #(
            .NUM_CLUSTERS (NUM_CLUSTERS)
        ) i_frontend (
            .clk_i                (clk_i),
            .rst_ni               (rst_ni),
            .task_valid_i         (task_valid_i[k]),
            .task_ready_o         (task_ready_o[k]),
            .task_i               (task_i[k]),
            .fb_valid_o           (fb_valid[k]),
            .fb_ready_i           (fb_ready[k]),
            .fb_o                 (fb[k]),
            .core_req_i           (core_req_i[k]),
            .core_rsp_o           (core_rsp_o[k]),
            .active_o             (active_o[k]),
            .disable_commands_o   (disable_commands_o[k]),
            .handler_terminated_o (handler_terminated_o[k])
        );
    end

    feedback_arbiter #(
        .NUM_PORTS (NUM_HPUS),
        .T         (feedback_descr_t)
    ) i_fb_arbiter (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_valid_i (fb_valid),
        .req_ready_o (fb_ready),
        .req_i       (fb),
        .allowed_i   (feedback_allowed_i),  // cluster-level permission
        .out_valid_o (feedback_valid_o),
        .out_ready_i (feedback_ready_i),
        .out_o       (feedback_o)
    );

endmodule

//--- verilog/hpu_mem_pkg.sv
/*
 * HPU core memory port
 * request and response channels between a core and its task frontend,
 * plus the offsets of the task register map
 */
package hpu_mem_pkg;

    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        logic [31:0] data;
    } core_req_chan_t;

    typedef struct packed {
        logic           q_valid;
        core_req_chan_t q;
        logic           p_ready;
    } core_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        error;
    } core_rsp_chan_t;

    typedef struct packed {
        logic           q_ready;
        logic           p_valid;
        core_rsp_chan_t p;
    } core_rsp_t;

    // task register map, low address byte
    localparam logic [7:0] REG_HANDLER_FUN      = 8'h00;
    localparam logic [7:0] REG_FUN_SIZE         = 8'h04;
    localparam logic [7:0] REG_HANDLER_MEM_ADDR = 8'h08;
    localparam logic [7:0] REG_HANDLER_MEM_SIZE = 8'h0c;
    localparam logic [7:0] REG_PKT_PTR          = 8'h10;
    localparam logic [7:0] REG_PKT_SIZE         = 8'h14;
    localparam logic [7:0] REG_SCRATCH_ADDR0    = 8'h18;
    localparam logic [7:0] REG_SCRATCH_ADDR1    = 8'h1c;
    localparam logic [7:0] REG_SCRATCH_SIZE0    = 8'h20;
    localparam logic [7:0] REG_SCRATCH_SIZE1    = 8'h24;
    localparam logic [7:0] REG_HOST_ADDR_HI     = 8'h28;
    localparam logic [7:0] REG_HOST_ADDR_LO     = 8'h2c;
    localparam logic [7:0] REG_HOST_MEM_SIZE    = 8'h30;
    localparam logic [7:0] REG_PKT_ADDR         = 8'h34;
    localparam logic [7:0] REG_HOME_CLUSTER     = 8'h38;
    localparam logic [7:0] REG_MSGID            = 8'h3c;
    localparam logic [7:0] REG_TERMINATE        = 8'h40;
    localparam logic [7:0] REG_ERROR            = 8'h44;

endpackage

//--- verilog/hpu_task_pkg.sv
/*
 * HPU task types
 * handler task as sent by the scheduler, the task held by a frontend
 * (handler task plus its L1 packet pointer) and the feedback descriptor
 * returned once the handler terminates
 */
package hpu_task_pkg;

    localparam int unsigned NUM_SCRATCHPADS = 2;

    // one handler invocation, as handed out by the scheduler
    typedef struct packed {
        logic [31:0]                      handler_fun;
        logic [31:0]                      handler_fun_size;
        logic [31:0]                      handler_mem_addr;
        logic [31:0]                      handler_mem_size;
        logic [31:0]                      pkt_addr;           // L2 address
        logic [31:0]                      pkt_size;
        logic [31:0]                      msgid;
        logic [NUM_SCRATCHPADS-1:0][31:0] scratchpad_addr;
        logic [NUM_SCRATCHPADS-1:0][31:0] scratchpad_size;
        logic [63:0]                      host_mem_addr;
        logic [31:0]                      host_mem_size;
        logic                             trigger_feedback;
    } handler_task_t;

    typedef struct packed {
        handler_task_t handler_task;
        logic [31:0]   pkt_ptr;       // L1 address of the packet copy
    } hpu_task_t;

    // sent back when the handler is done with the packet
    typedef struct packed {
        logic [31:0] pkt_ptr;
        logic [31:0] pkt_addr;
        logic [31:0] msgid;
        logic [31:0] pkt_size;
        logic        trigger_feedback;
        logic [7:0]  hpu_id;          // set by the group arbiter
    } feedback_descr_t;

endpackage

//--- verilog/stream_fifo.sv
/*
 * stream FIFO
 * valid/ready FIFO of DEPTH entries of payload type T, circular buffer
 * with read and write pointers and a fill count. Not fall-through, so a
 * pushed entry shows up at the output one cycle later.
 */
`timescale 1ns/1ns

module stream_fifo #(
    parameter int unsigned DEPTH = 2,
    parameter type         T     = logic
) (
    input  logic clk_i,
    input  logic rst_ni,

    input  T     data_i,
    input  logic valid_i,
    output logic ready_o,

    output T     data_o,
    output logic valid_o,
    input  logic ready_i
);

    localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CntW = $clog2(DEPTH + 1);

    T                mem_q [DEPTH];
    logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
    logic [CntW-1:0] count_q;
    logic            push, pop;

    function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
        logic [PtrW-1:0] nxt;
        nxt = (ptr == PtrW'(DEPTH - 1)) ? '0 : ptr + 1'b1; // wrap at the last slot
        return nxt;
    endfunction

    assign ready_o = (count_q < CntW'(DEPTH));
    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q];

    assign push = valid_i && ready_o;
    assign pop  = valid_o && ready_i;

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;    // idle or push and pop together
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

//--- verilog/task_frontend.sv
/*
 * HPU task frontend
 * takes one handler task from the scheduler and holds it while the
 * handler runs, answers the core's loads from the task register map and
 * builds the feedback descriptor when the handler reads the termination
 * register. Feedback and core responses are buffered in stream FIFOs.
 */
`timescale 1ns/1ns

module task_frontend #(
    parameter int unsigned NUM_CLUSTERS = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,

    // task from the scheduler
    input  logic                          task_valid_i,
    output logic                          task_ready_o,
    input  hpu_task_pkg::hpu_task_t       task_i,

    // feedback towards the arbiter
    output logic                          fb_valid_o,
    input  logic                          fb_ready_i,
    output hpu_task_pkg::feedback_descr_t fb_o,

    // core memory port
    input  hpu_mem_pkg::core_req_t        core_req_i,
    output hpu_mem_pkg::core_rsp_t        core_rsp_o,

    output logic                          active_o,
    output logic                          disable_commands_o,
    output logic                          handler_terminated_o
);

    import hpu_task_pkg::*;
    import hpu_mem_pkg::*;

    localparam int unsigned ClusterBits = (NUM_CLUSTERS > 1) ? $clog2(NUM_CLUSTERS) : 1;

    typedef enum logic [1:0] {Init, Idle, Running, StallingFeedback} state_t;

    state_t                 state_d, state_q;
    hpu_task_t              cur_task_q;
    handler_task_t          cur;
    logic                   task_acc;
    logic                   req_acc;
    logic                   term_read;
    logic [ClusterBits-1:0] home_cluster;

    feedback_descr_t        fb_new;
    logic                   fb_push;
    logic                   fb_space;

    core_rsp_chan_t         rsp;
    core_rsp_chan_t         rsp_out;
    logic                   rsp_out_valid;

    assign cur          = cur_task_q.handler_task;
    assign home_cluster = cur.msgid[ClusterBits-1:0];

    // no new task while a feedback still waits in the buffer
    assign task_ready_o = (state_q == Idle) && fb_space;
    assign task_acc     = task_valid_i && task_ready_o;

    // requests only taken while a handler runs
    assign req_acc = (state_q == Running) && core_req_i.q_valid;

    assign active_o             = (state_q != Init);
    assign disable_commands_o   = fb_valid_o;
    assign handler_terminated_o = term_read;

    // feedback descriptor straight from the held task
    always_comb begin
        fb_new                  = '0;
        fb_new.pkt_ptr          = cur_task_q.pkt_ptr;
        fb_new.pkt_addr         = cur.pkt_addr;
        fb_new.msgid            = cur.msgid;
        fb_new.pkt_size         = cur.pkt_size;
        fb_new.trigger_feedback = cur.trigger_feedback;
    end

    assign fb_push = term_read || (state_q == StallingFeedback);

    stream_fifo #(
        .DEPTH (1),
        .T     (feedback_descr_t)
    ) i_fb_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .data_i  (fb_new),
        .valid_i (fb_push),
        .ready_o (fb_space),
        .data_o  (fb_o),
        .valid_o (fb_valid_o),
        .ready_i (fb_ready_i)
    );

    // one response per accepted request, core never has two outstanding
    stream_fifo #(
        .DEPTH (2),
        .T     (core_rsp_chan_t)
    ) i_rsp_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .data_i  (rsp),
        .valid_i (req_acc),
        .ready_o (),
        .data_o  (rsp_out),
        .valid_o (rsp_out_valid),
        .ready_i (core_req_i.p_ready)
    );

    assign core_rsp_o = '{q_ready: req_acc, p_valid: rsp_out_valid, p: rsp_out};

    // register map decode
    always_comb begin
        rsp       = '0;
        term_read = 1'b0;
        if (req_acc) begin
            case (core_req_i.q.addr[7:0])
                REG_HANDLER_FUN:      rsp.data = cur.handler_fun;
                REG_FUN_SIZE:         rsp.data = cur.handler_fun_size;
                REG_HANDLER_MEM_ADDR: rsp.data = cur.handler_mem_addr;
                REG_HANDLER_MEM_SIZE: rsp.data = cur.handler_mem_size;
                REG_PKT_PTR:          rsp.data = cur_task_q.pkt_ptr;
                REG_PKT_SIZE:         rsp.data = cur.pkt_size;
                REG_SCRATCH_ADDR0:    rsp.data = cur.scratchpad_addr[0];
                REG_SCRATCH_ADDR1:    rsp.data = cur.scratchpad_addr[1];
                REG_SCRATCH_SIZE0:    rsp.data = cur.scratchpad_size[0];
                REG_SCRATCH_SIZE1:    rsp.data = cur.scratchpad_size[1];
                REG_HOST_ADDR_HI:     rsp.data = cur.host_mem_addr[63:32];
                REG_HOST_ADDR_LO:     rsp.data = cur.host_mem_addr[31:0];
                REG_HOST_MEM_SIZE:    rsp.data = cur.host_mem_size;
                REG_PKT_ADDR:         rsp.data = cur.pkt_addr;
                REG_HOME_CLUSTER:     rsp.data = 32'(home_cluster);
                REG_MSGID:            rsp.data = cur.msgid;
                REG_TERMINATE: begin
                    // reading here ends the handler
                    term_read = !core_req_i.q.write;
                end
                REG_ERROR: begin
                    rsp.data = '0;    // acknowledged only
                end
                default: begin
                    rsp.error = 1'b1;
                end
            endcase
        end
    end

    // task state
    always_comb begin
        state_d = state_q;
        case (state_q)
            Init: begin
                if (core_req_i.q_valid) begin // boot poll, left pending
                    state_d = Idle;
                end
            end
            Idle: begin
                if (task_acc) begin
                    state_d = (task_i.handler_task.handler_fun == '0) ? StallingFeedback
                                                                      : Running;
                end
            end
            Running: begin
                if (term_read) begin
                    state_d = fb_space ? Idle : StallingFeedback;
                end
            end
            StallingFeedback: begin
                if (fb_space) begin  // feedback pushed this cycle
                    state_d = Idle;
                end
            end
            default: begin
                state_d = Idle;
            end
        endcase
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= Init;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (task_acc) begin
            cur_task_q <= task_i;
        end
    end

endmodule
